// File: Makefile
TOP = tb_rv_core

all: run

compile:
	verilator --binary --timing -f project.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: dv/core_vectors.hex
// columns: expected pc, instruction, retire {0, wrote, illegal, rd[4:0]} then data, ecall flag
// branches jump by 8 when taken, so skipped addresses have no line
00000000 00500093 4100000005 0
00000004 FFD00113 42FFFFFFFD 0
00000008 402081B3 4300000008 0
0000000C 40115233 44FFFFFFFF 0
00000010 001122B3 4500000001 0
00000014 00713313 4600000000 0
00000018 0FF0C393 47000000FA 0
0000001C 00409413 4800000050 0
00000020 00908013 400000000E 0
00000024 001064B3 4900000005 0
00000028 12345537 4A12345000 0
0000002C 00001597 4B0000102C 0
00000030 00908463 0000000000 0
00000038 00909463 0000000000 0
0000003C 00114463 0000000000 0
00000044 00115463 0000000000 0
00000048 00116463 0000000000 0
0000004C 00117463 0000000000 0
00000054 00C0066F 4C00000058 0
00000060 041406E7 4D00000064 0
00000090 0000000B 2000000000 0
00000094 00000073 0000000000 1

// File: dv/tb_rv_core.sv
// testbench for rv_core that serves instructions from a vector file with random stalls
`timescale 1ns/1ps

module tb_rv_core;

  localparam int NUM_VEC = 22;
  localparam int READY_LIMIT = 16;
  localparam int HOLD_CYCLES = 5;
  // up to 3 stall cycles plus the accept per vector, with room to spare
  localparam int WATCHDOG_CYCLES = NUM_VEC * 8 + 40;

  logic            clk;
  logic            rst;
  rv_pkg::word_t   insn;
  logic            insn_valid;
  logic            insn_ready;
  rv_pkg::word_t   pc;
  rv_pkg::retire_t retire;
  logic            halt;

  // four words per vector: pc, instruction, retire fields, ecall flag
  logic [39:0]   vec_mem [0:NUM_VEC*4-1];
  logic [31:0]   rng_state;
  rv_pkg::word_t last_pc;
  int            error_count;
  int            test_count;
  int            fail_count;

  rv_core #(
    .RESET_PC (32'h0000_0000)
  ) DUT (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .insn_valid (insn_valid),
    .insn_ready (insn_ready),
    .pc         (pc),
    .retire     (retire),
    .halt       (halt)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: failed", name);
      fail_count++;
    end
  endtask

  task automatic run_vector(input int idx);
    rv_pkg::word_t exp_pc;
    rv_pkg::word_t word;
    logic [39:0]   exp_ret;
    logic          is_ecall;
    int            stall;
    int            waited;
    int            errs_before;
    errs_before = error_count;
    exp_pc = vec_mem[idx*4][31:0];
    word = vec_mem[idx*4+1][31:0];
    exp_ret = vec_mem[idx*4+2];
    is_ecall = vec_mem[idx*4+3][0];
    rng_state = xorshift32(rng_state);
    stall = int'(rng_state % 32'd4);
    // pc must hold and nothing retires while idle
    repeat (stall) begin
      @(posedge clk);
      #1;
      compare_value("retire.valid", {31'd0, retire.valid}, 32'd0);
      compare_value("pc", pc, exp_pc);
    end
    compare_value("pc", pc, exp_pc);
    insn = word;
    insn_valid = 1'b1;
    waited = 0;
    while (insn_ready !== 1'b1 && waited < READY_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (insn_ready !== 1'b1) begin
      $display("insn_ready never rose for vector %0d", idx);
      error_count++;
    end else begin
      // retire record is registered on the accepting edge
      @(posedge clk);
      #1;
      compare_value("retire.valid", {31'd0, retire.valid}, 32'd1);
      compare_value("retire.pc", retire.pc, exp_pc);
      compare_value("retire.wrote", {31'd0, retire.wrote}, {31'd0, exp_ret[38]});
      compare_value("retire.illegal", {31'd0, retire.illegal}, {31'd0, exp_ret[37]});
      compare_value("retire.rd", {27'd0, retire.rd}, {27'd0, exp_ret[36:32]});
      compare_value("retire.data", retire.data, exp_ret[31:0]);
      compare_value("halt", {31'd0, halt}, {31'd0, is_ecall});
      compare_value("insn_ready", {31'd0, insn_ready}, {31'd0, ~is_ecall});
    end
    insn_valid = 1'b0;
    insn = '0;
    last_pc = exp_pc;
    report_test($sformatf("vector %0d at pc 0x%08h", idx, exp_pc), errs_before);
  endtask

  initial begin
    int errs_before;
    clk = 1'b0;
    rst = 1'b1;
    insn = '0;
    insn_valid = 1'b0;
    rng_state = 32'h55a50227;
    last_pc = '0;
    error_count = 0;
    test_count = 0;
    fail_count = 0;
    // entries the file does not reach keep a value no ecall flag can have
    for (int i = 0; i < NUM_VEC*4; i++) begin
      vec_mem[i] = {8'ha5, 32'(i)};
    end
    $readmemh("dv/core_vectors.hex", vec_mem);
    if (vec_mem[NUM_VEC*4-1] > 40'd1) begin
      $display("vector file dv/core_vectors.hex could not be read completely");
      error_count++;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    errs_before = error_count;
    compare_value("pc", pc, 32'h0000_0000);
    compare_value("retire.valid", {31'd0, retire.valid}, 32'd0);
    compare_value("halt", {31'd0, halt}, 32'd0);
    compare_value("insn_ready", {31'd0, insn_ready}, 32'd1);
    report_test("reset state", errs_before);

    for (int i = 0; i < NUM_VEC; i++) begin
      run_vector(i);
    end

    // after ecall the core ignores further offers
    errs_before = error_count;
    insn = 32'h0010_0093;
    insn_valid = 1'b1;
    repeat (HOLD_CYCLES) begin
      @(posedge clk);
      #1;
      compare_value("halt", {31'd0, halt}, 32'd1);
      compare_value("insn_ready", {31'd0, insn_ready}, 32'd0);
      compare_value("retire.valid", {31'd0, retire.valid}, 32'd0);
      compare_value("pc", pc, last_pc + 32'd4);
    end
    insn_valid = 1'b0;
    report_test("halt holds after ecall", errs_before);

    $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: hw/alu.sv
// integer alu for add, sub, logic, shifts and set-less-than
`timescale 1ns/1ps

module alu (
  input  rv_pkg::decode_t dec,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   imm,
  input  rv_pkg::word_t   pc,
  output rv_pkg::word_t   result
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  logic [4:0]    shamt;

  // lui adds its immediate to zero, auipc to the pc
  always_comb begin
    if (dec.a_zero) begin
      op_a = '0;
    end else if (dec.a_pc) begin
      op_a = pc;
    end else begin
      op_a = rs1_data;
    end
  end

  assign op_b = dec.b_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD:  result = op_a + op_b;
      rv_pkg::ALU_SUB:  result = op_a - op_b;
      rv_pkg::ALU_SLL:  result = op_a << shamt;
      rv_pkg::ALU_SLT:  result = {31'd0, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU: result = {31'd0, op_a < op_b};
      rv_pkg::ALU_XOR:  result = op_a ^ op_b;
      rv_pkg::ALU_SRL:  result = op_a >> shamt;
      rv_pkg::ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:   result = op_a | op_b;
      rv_pkg::ALU_AND:  result = op_a & op_b;
      default:          result = '0;
    endcase
  end

endmodule

// File: hw/core_control.sv
// core control with instruction decode, fetch handshake, halt state and retire record
`timescale 1ns/1ps

module core_control (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    insn,
  input  logic             insn_valid,
  output logic             insn_ready,
  output rv_pkg::decode_t  dec,
  output logic             accept,
  output rv_pkg::word_t    rd_data,
  input  rv_pkg::word_t    alu_result,
  input  rv_pkg::word_t    link,
  input  rv_pkg::word_t    pc,
  output rv_pkg::retire_t  retire,
  output logic             halt
);

  logic       halted;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // alt selects sub or sra where funct3 allows it
  function automatic rv_pkg::alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_from_funct = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  alu_from_funct = rv_pkg::ALU_SLL;
      3'b010:  alu_from_funct = rv_pkg::ALU_SLT;
      3'b011:  alu_from_funct = rv_pkg::ALU_SLTU;
      3'b100:  alu_from_funct = rv_pkg::ALU_XOR;
      3'b101:  alu_from_funct = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  alu_from_funct = rv_pkg::ALU_OR;
      default: alu_from_funct = rv_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    dec = '0;
    dec.alu_op = rv_pkg::ALU_ADD;
    dec.imm_sel = rv_pkg::IMM_I;
    dec.funct3 = funct3;
    case (insn[6:0])
      rv_pkg::OP_LUI: begin
        dec.a_zero = 1'b1;
        dec.b_imm = 1'b1;
        dec.imm_sel = rv_pkg::IMM_U;
        dec.rd_write = 1'b1;
      end
      rv_pkg::OP_AUIPC: begin
        dec.a_pc = 1'b1;
        dec.b_imm = 1'b1;
        dec.imm_sel = rv_pkg::IMM_U;
        dec.rd_write = 1'b1;
      end
      rv_pkg::OP_JAL: begin
        dec.jal = 1'b1;
        dec.imm_sel = rv_pkg::IMM_J;
        dec.rd_write = 1'b1;
      end
      rv_pkg::OP_JALR: begin
        dec.jalr = 1'b1;
        dec.rd_write = 1'b1;
        dec.illegal = (funct3 != 3'b000);
      end
      rv_pkg::OP_BRANCH: begin
        dec.branch = 1'b1;
        dec.imm_sel = rv_pkg::IMM_B;
        // 010 and 011 are not branch conditions
        dec.illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      rv_pkg::OP_REG_IMM: begin
        dec.b_imm = 1'b1;
        dec.rd_write = 1'b1;
        dec.alu_op = alu_from_funct(funct3, (funct3 == 3'b101) && insn[30]);
        if (funct3 == 3'b001) begin
          dec.illegal = (funct7 != 7'd0);
        end else if (funct3 == 3'b101) begin
          dec.illegal = (funct7 != 7'd0) && (funct7 != rv_pkg::F7_ALT);
        end
      end
      rv_pkg::OP_REG_REG: begin
        dec.rd_write = 1'b1;
        dec.alu_op = alu_from_funct(funct3, insn[30]);
        // only add/sub and srl/sra have an alternate encoding
        dec.illegal = !((funct7 == 7'd0) ||
                        ((funct7 == rv_pkg::F7_ALT) && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      rv_pkg::OP_SYSTEM: begin
        dec.ecall = (insn[31:7] == 25'd0);
        dec.illegal = !dec.ecall;
      end
      default: dec.illegal = 1'b1;
    endcase
    // illegal retires as a plain pc + 4
    if (dec.illegal) begin
      dec.rd_write = 1'b0;
      dec.branch = 1'b0;
      dec.jalr = 1'b0;
    end
  end

  assign insn_ready = !halted;
  assign accept = insn_valid && insn_ready;
  assign halt = halted;
  assign rd_data = (dec.jal || dec.jalr) ? link : alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
      retire <= '0;
    end else if (accept) begin
      halted <= dec.ecall;
      retire.valid <= 1'b1;
      retire.wrote <= dec.rd_write;
      retire.illegal <= dec.illegal;
      retire.rd <= dec.rd_write ? insn[11:7] : '0;
      retire.data <= dec.rd_write ? rd_data : '0;
      retire.pc <= pc;
    end else begin
      retire.valid <= 1'b0;
    end
  end

endmodule

// File: hw/imm_gen.sv
// immediate generator for the I, S, B, J and U instruction formats
`timescale 1ns/1ps

module imm_gen (
  input  rv_pkg::word_t    insn,
  input  rv_pkg::imm_sel_e sel,
  output rv_pkg::word_t    imm
);

  logic sign;

  assign sign = insn[31];

  always_comb begin
    case (sel)
      rv_pkg::IMM_I: imm = {{20{sign}}, insn[31:20]};
      rv_pkg::IMM_S: imm = {{20{sign}}, insn[31:25], insn[11:7]};
      // branch offsets are in halfwords
      rv_pkg::IMM_B: imm = {{19{sign}}, sign, insn[7], insn[30:25], insn[11:8], 1'b0};
      rv_pkg::IMM_J: imm = {{11{sign}}, sign, insn[19:12], insn[20], insn[30:21], 1'b0};
      rv_pkg::IMM_U: imm = {insn[31:12], 12'd0};
      default:       imm = '0;
    endcase
  end

endmodule

// File: hw/pc_unit.sv
// program counter with branch evaluation and next-pc selection
`timescale 1ns/1ps

module pc_unit #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::decode_t dec,
  input  logic            accept,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   imm,
  output rv_pkg::word_t   pc,
  output rv_pkg::word_t   link
);

  logic          taken;
  rv_pkg::word_t next_pc;

  always_comb begin
    case (dec.funct3)
      rv_pkg::F3_BEQ:  taken = (rs1_data == rs2_data);
      rv_pkg::F3_BNE:  taken = (rs1_data != rs2_data);
      rv_pkg::F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::F3_BLTU: taken = (rs1_data < rs2_data);
      rv_pkg::F3_BGEU: taken = (rs1_data >= rs2_data);
      default:         taken = 1'b0;
    endcase
  end

  assign link = pc + 32'd4;

  always_comb begin
    if (dec.jal || (dec.branch && taken)) begin
      next_pc = pc + imm;
    end else if (dec.jalr) begin
      // jalr target drops bit 0
      next_pc = (rs1_data + imm) & ~32'd1;
    end else begin
      next_pc = link;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (accept) begin
      pc <= next_pc;
    end
  end

endmodule

// File: hw/reg_file.sv
// integer register file with two combinational read ports and x0 held at zero
`timescale 1ns/1ps

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  rv_pkg::reg_idx_t rd,
  input  logic             we,
  input  rv_pkg::word_t    rd_data
);

  // x0 has no storage
  rv_pkg::word_t regs [1:31];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

// File: hw/rv_core.sv
// single-cycle rv32i core top level wiring control, immediates, registers, alu and pc
`timescale 1ns/1ps

module rv_core #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::word_t   insn,
  input  logic            insn_valid,
  output logic            insn_ready,
  output rv_pkg::word_t   pc,
  output rv_pkg::retire_t retire,
  output logic            halt
);

  rv_pkg::decode_t dec;
  logic            accept;
  rv_pkg::word_t   imm;
  rv_pkg::word_t   rs1_data;
  rv_pkg::word_t   rs2_data;
  rv_pkg::word_t   alu_result;
  rv_pkg::word_t   rd_data;
  rv_pkg::word_t   link;

  core_control u_control (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .insn_valid (insn_valid),
    .insn_ready (insn_ready),
    .dec        (dec),
    .accept     (accept),
    .rd_data    (rd_data),
    .alu_result (alu_result),
    .link       (link),
    .pc         (pc),
    .retire     (retire),
    .halt       (halt)
  );

  imm_gen u_imm (
    .insn (insn),
    .sel  (dec.imm_sel),
    .imm  (imm)
  );

  // write lands on the accepting edge only
  reg_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .rs1      (insn[19:15]),
    .rs2      (insn[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (insn[11:7]),
    .we       (accept && dec.rd_write),
    .rd_data  (rd_data)
  );

  alu u_alu (
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .pc       (pc),
    .result   (alu_result)
  );

  pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_pc (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec),
    .accept   (accept),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .pc       (pc),
    .link     (link)
  );

endmodule

// File: hw/rv_pkg.sv
// rv32i core package with widths, opcodes, function codes and shared structs
package rv_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [REG_ADDR_W-1:0] reg_idx_t;

  // major opcodes kept in this core
  typedef enum logic [6:0] {
    OP_LUI     = 7'b0110111,
    OP_AUIPC   = 7'b0010111,
    OP_JAL     = 7'b1101111,
    OP_JALR    = 7'b1100111,
    OP_BRANCH  = 7'b1100011,
    OP_REG_IMM = 7'b0010011,
    OP_REG_REG = 7'b0110011,
    OP_SYSTEM  = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_B, IMM_J, IMM_U
  } imm_sel_e;

  // branch conditions in funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct7 of sub and sra
  localparam logic [6:0] F7_ALT = 7'b0100000;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       b_imm;
    logic       a_pc;
    logic       a_zero;
    imm_sel_e   imm_sel;
    logic       rd_write;
    logic       branch;
    logic       jal;
    logic       jalr;
    logic [2:0] funct3;
    logic       illegal;
    logic       ecall;
  } decode_t;

  typedef struct packed {
    logic     valid;
    logic     wrote;
    logic     illegal;
    reg_idx_t rd;
    word_t    data;
    word_t    pc;
  } retire_t;

endpackage

// File: project.f
hw/rv_pkg.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/alu.sv
hw/pc_unit.sv
hw/core_control.sv
hw/rv_core.sv
dv/tb_rv_core.sv
